// File: hdl/scope_cfg.svh
// digitizer core configuration
// widths, buffer depth, firmware version and fixed reply codes

`ifndef SCOPE_CFG_SVH
`define SCOPE_CFG_SVH

// ------------------------------------------------------------------
// datapath sizes
// ------------------------------------------------------------------
`define SCOPE_SAMPLE_W   12   // adc sample bits
`define SCOPE_RAM_AW     10   // 1024 entry sample buffer
`define SCOPE_CMD_BYTES  8    // bytes per host command

// ------------------------------------------------------------------
// reply constants
// ------------------------------------------------------------------
`define SCOPE_VERSION    16   // firmware version word
`define SCOPE_SET_ACK    37   // answer to trigger settings
`define SCOPE_THR_BIAS   128  // threshold byte offset

`endif

// File: hdl/scope_cmd_pkg.sv
// command side types
// host command bytes, opcodes and reply requests to the streamer

`include "scope_cfg.svh"

package scope_cmd_pkg;

	// byte 0 is the opcode, bytes 1..7 are arguments
	typedef logic [`SCOPE_CMD_BYTES-1:0][7:0] cmd_t;

	typedef enum logic [7:0] {
		OP_READOUT  = 8'd0,   // buffer dump
		OP_ARM      = 8'd1,   // arm and status
		OP_INFO     = 8'd2,   // version read
		OP_TRIG_SET = 8'd8    // thresholds, preoffset, tot
	} opcode_e;

	typedef enum logic {
		RESP_WORD = 1'b0,     // single constant beat
		RESP_DUMP = 1'b1      // words read from the buffer
	} resp_kind_e;

	typedef struct packed {
		resp_kind_e               kind;
		logic [31:0]              word;   // constant reply data
		logic [`SCOPE_RAM_AW-1:0] start;  // first buffer address of a dump
		logic [31:0]              len;    // dump length in bytes
	} resp_req_t;

endpackage

// File: hdl/scope_acq_pkg.sv
// acquisition side types
// samples, trigger settings and the status seen by the host

`include "scope_cfg.svh"

package scope_acq_pkg;

	typedef logic signed [`SCOPE_SAMPLE_W-1:0] sample_t;
	typedef logic [`SCOPE_RAM_AW-1:0]          ram_addr_t;

	typedef enum logic [7:0] {
		TRIG_NONE = 8'd0,     // trigger on arm
		TRIG_FALL = 8'd1,     // below lower, then above upper
		TRIG_RISE = 8'd2      // above upper, then below lower
	} trig_type_e;

	typedef struct packed {
		trig_type_e  ttype;
		sample_t     lower;
		sample_t     upper;
		logic [7:0]  tot;       // extra samples past threshold before firing
		logic [15:0] post_len;  // samples written after the trigger
	} trig_cfg_t;

	typedef struct packed {
		logic [15:0] event_cnt;
		logic [15:0] trig_cnt;  // post samples so far, all ones in hold
		ram_addr_t   trig_addr; // where the firing sample landed
	} acq_status_t;

endpackage

// File: hdl/cmd_receiver.sv
// command receiver
// collects eight bytes from the input stream into one command

`include "scope_cfg.svh"

module cmd_receiver
	import scope_cmd_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	input  logic       i_tvalid,
	input  logic [7:0] i_tdata,
	output logic       o_tready,
	input  logic       i_cmd_done,
	output cmd_t       o_cmd,
	output logic       o_cmd_valid
);

	localparam int CNT_W = $clog2(`SCOPE_CMD_BYTES);

	logic [CNT_W-1:0] byte_cnt;
	logic             busy;   // command held until executor is done
	logic             take;
	logic             last_byte;

	assign o_tready  = !busy;
	assign take      = i_tvalid && o_tready;
	assign last_byte = (byte_cnt == CNT_W'(`SCOPE_CMD_BYTES - 1));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt    <= '0;
			busy        <= 1'b0;
			o_cmd_valid <= 1'b0;
		end else begin
			o_cmd_valid <= take && last_byte;
			if (take) begin
				byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
				busy     <= last_byte;
			end else if (i_cmd_done) begin
				busy <= 1'b0;  // reopen input
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			o_cmd[byte_cnt] <= i_tdata;
	end

endmodule

// File: hdl/cmd_executor.sv
// command executor
// decodes opcodes, keeps the trigger settings and asks the
// streamer for a reply; unknown commands finish without one

`include "scope_cfg.svh"

module cmd_executor
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  cmd_t        i_cmd,
	input  logic        i_cmd_valid,
	output logic        o_cmd_done,
	output trig_cfg_t   o_trig_cfg,
	output logic        o_arm,
	output logic        o_release,
	input  acq_status_t i_acq_status,
	output resp_req_t   o_resp_req,
	output logic        o_resp_valid,
	input  logic        i_resp_done
);

	localparam int SW = `SCOPE_SAMPLE_W;

	ram_addr_t     preoffset;     // samples shown before the trigger
	logic          dump_pending;
	logic          bad_done;      // command finished without a reply
	logic [SW-1:0] thr_lo;
	logic [SW-1:0] thr_hi;
	resp_req_t     req_d;
	logic          req_ok;

	// byte1 is the centre, byte2 the half width, scaled to adc counts
	assign thr_lo = ((SW'(i_cmd[1]) - SW'(i_cmd[2]) - SW'(`SCOPE_THR_BIAS)) << 4) + SW'(8);
	assign thr_hi = ((SW'(i_cmd[1]) + SW'(i_cmd[2]) - SW'(`SCOPE_THR_BIAS)) << 4) + SW'(8);

	assign o_cmd_done = bad_done || i_resp_done;  // same cycle as the streamer's done

	// ------------------------------------------------------------------
	// reply decode
	// ------------------------------------------------------------------
	always_comb begin
		req_d.kind  = RESP_WORD;
		req_d.word  = '0;
		req_d.start = i_acq_status.trig_addr - preoffset;  // wraps around the buffer
		req_d.len   = 32'd4;
		req_ok      = 1'b1;
		case (i_cmd[0])
			OP_READOUT: begin
				req_d.kind = RESP_DUMP;
				req_d.len  = i_cmd[7:4];  // byte 7 high
			end
			OP_ARM:      req_d.word = {i_acq_status.event_cnt, i_acq_status.trig_cnt};
			OP_INFO: begin
				if (i_cmd[1] == 8'd0)
					req_d.word = 32'(`SCOPE_VERSION);
				else
					req_ok = 1'b0;  // other info pages not present
			end
			OP_TRIG_SET: req_d.word = 32'(`SCOPE_SET_ACK);
			default:     req_ok = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------
	// settings and handshakes
	// ------------------------------------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_trig_cfg   <= '0;
			preoffset    <= '0;
			o_arm        <= 1'b0;
			o_release    <= 1'b0;
			o_resp_valid <= 1'b0;
			bad_done     <= 1'b0;
			dump_pending <= 1'b0;
		end else begin
			o_arm        <= 1'b0;
			o_release    <= 1'b0;
			o_resp_valid <= 1'b0;
			bad_done     <= 1'b0;
			if (i_cmd_valid) begin
				o_resp_valid <= req_ok;
				bad_done     <= !req_ok;
				case (i_cmd[0])
					OP_TRIG_SET: begin
						o_trig_cfg.lower <= sample_t'(thr_lo);
						o_trig_cfg.upper <= sample_t'(thr_hi);
						o_trig_cfg.tot   <= i_cmd[5];
						preoffset        <= {i_cmd[3][1:0], i_cmd[4]};
					end
					OP_ARM: begin
						o_trig_cfg.ttype    <= trig_type_e'(i_cmd[1]);
						o_trig_cfg.post_len <= i_cmd[5:4];
						o_arm               <= (i_acq_status.trig_cnt == 16'd0);  // only if idle
					end
					OP_READOUT:  dump_pending <= 1'b1;
					default:     ;
				endcase
			end
			if (i_resp_done) begin
				o_release    <= dump_pending;  // event read, let engine rearm
				dump_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_cmd_valid)
			o_resp_req <= req_d;
	end

endmodule

// File: hdl/trigger_engine.sv
// trigger engine
// registers each sample, runs the threshold trigger with time over
// threshold, addresses the circular buffer and counts events

module trigger_engine
	import scope_acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  sample_t     i_sample,
	input  trig_cfg_t   i_cfg,
	input  logic        i_arm,
	input  logic        i_release,
	output acq_status_t o_status,
	output logic        o_wr_en,
	output ram_addr_t   o_wr_addr,
	output sample_t     o_wr_data
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_FALL_LO,   // waiting for a sample below lower
		S_FALL_HI,   // counting samples above upper
		S_RISE_HI,
		S_RISE_LO,
		S_POST,
		S_HOLD       // event kept for readout, no writes
	} state_e;

	state_e      state;
	sample_t     smp_q;
	ram_addr_t   wr_addr;
	logic [7:0]  tot_cnt;
	acq_status_t status;
	logic        above;
	logic        below;
	logic        fire;
	logic        post_done;

	assign above = smp_q > i_cfg.upper;
	assign below = smp_q < i_cfg.lower;

	always_comb begin
		case (state)
			S_IDLE:    fire = i_arm && (i_cfg.ttype != TRIG_FALL) && (i_cfg.ttype != TRIG_RISE);
			S_FALL_HI: fire = above && (tot_cnt >= i_cfg.tot);
			S_RISE_LO: fire = below && (tot_cnt >= i_cfg.tot);
			default:   fire = 1'b0;
		endcase
	end

	assign post_done = (fire && i_cfg.post_len == 16'd0) ||
	                   (state == S_POST && status.trig_cnt + 16'd1 == i_cfg.post_len);

	assign o_wr_en   = (state != S_HOLD);
	assign o_wr_addr = wr_addr;
	assign o_wr_data = smp_q;
	assign o_status  = status;

	always_ff @(posedge clk) begin
		smp_q <= i_sample;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state   <= S_IDLE;
			wr_addr <= '0;
			tot_cnt <= '0;
			status  <= '0;
		end else begin
			if (o_wr_en)
				wr_addr <= wr_addr + 1'b1;  // wraps with the buffer
			case (state)
				S_IDLE: begin
					status.trig_cnt <= '0;
					tot_cnt         <= '0;
					if (i_arm && i_cfg.ttype == TRIG_FALL)
						state <= S_FALL_LO;
					else if (i_arm && i_cfg.ttype == TRIG_RISE)
						state <= S_RISE_HI;
				end
				S_FALL_LO: if (below) state <= S_FALL_HI;
				S_FALL_HI: if (above) tot_cnt <= tot_cnt + 8'd1;
				S_RISE_HI: if (above) state <= S_RISE_LO;
				S_RISE_LO: if (below) tot_cnt <= tot_cnt + 8'd1;
				S_POST:    status.trig_cnt <= status.trig_cnt + 16'd1;
				S_HOLD:    if (i_release) state <= S_IDLE;
				default:   state <= S_IDLE;
			endcase
			if (fire) begin
				status.trig_addr <= wr_addr;
				state            <= S_POST;
			end
			if (post_done) begin
				status.event_cnt <= status.event_cnt + 16'd1;
				status.trig_cnt  <= '1;  // host sees 0xffff while held
				state            <= S_HOLD;
			end
		end
	end

endmodule

// File: hdl/sample_buffer.sv
// sample buffer
// circular simple dual-port sample RAM, one write and one
// registered read port

module sample_buffer
	import scope_acq_pkg::*;
(
	input  logic      clk,
	input  logic      i_wr_en,
	input  ram_addr_t i_wr_addr,
	input  sample_t   i_wr_data,
	input  ram_addr_t i_rd_addr,
	output sample_t   o_rd_data
);

	localparam int DEPTH = 2 ** $bits(ram_addr_t);

	sample_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
		o_rd_data <= mem[i_rd_addr];  // data one cycle after address
	end

endmodule

// File: hdl/response_streamer.sv
// response streamer
// sends constant replies and buffer dumps as 32-bit stream beats,
// two samples per dump word, keep and last from bytes remaining

module response_streamer
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  resp_req_t   i_req,
	input  logic        i_req_valid,
	output logic        o_req_done,
	output ram_addr_t   o_rd_addr,
	input  sample_t     i_rd_data,
	output logic        o_tvalid,
	output logic [31:0] o_tdata,
	output logic [3:0]  o_tkeep,
	output logic        o_tlast,
	input  logic        i_tready
);

	localparam int PAD = 16 - $bits(sample_t);

	typedef enum logic [2:0] {
		S_IDLE,
		S_RD_LO,   // first sample address at the RAM
		S_RD_HI,   // second address out, first sample back
		S_PACK,
		S_SEND
	} state_e;

	state_e      state;
	ram_addr_t   rd_addr;
	sample_t     lo_q;
	logic [31:0] remaining;

	assign o_rd_addr = rd_addr;
	assign o_tlast   = (remaining <= 32'd4);

	always_comb begin
		case (remaining)
			32'd0:   o_tkeep = 4'b0000;
			32'd1:   o_tkeep = 4'b0001;
			32'd2:   o_tkeep = 4'b0011;
			32'd3:   o_tkeep = 4'b0111;
			default: o_tkeep = 4'b1111;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state      <= S_IDLE;
			rd_addr    <= '0;
			remaining  <= '0;
			o_tvalid   <= 1'b0;
			o_req_done <= 1'b0;
		end else begin
			o_req_done <= 1'b0;
			case (state)
				S_IDLE: if (i_req_valid) begin
					rd_addr <= i_req.start;
					if (i_req.kind == RESP_WORD) begin
						remaining <= 32'd4;
						o_tvalid  <= 1'b1;
						state     <= S_SEND;
					end else if (i_req.len == 32'd0) begin
						o_req_done <= 1'b1;  // empty dump
					end else begin
						remaining <= i_req.len;
						state     <= S_RD_LO;
					end
				end
				S_RD_LO: begin
					rd_addr <= rd_addr + 1'b1;
					state   <= S_RD_HI;
				end
				S_RD_HI: begin
					rd_addr <= rd_addr + 1'b1;
					state   <= S_PACK;
				end
				S_PACK: begin
					o_tvalid <= 1'b1;
					state    <= S_SEND;
				end
				S_SEND: if (i_tready) begin
					o_tvalid <= 1'b0;
					if (o_tlast) begin
						o_req_done <= 1'b1;
						state      <= S_IDLE;
					end else begin
						remaining <= remaining - 32'd4;
						state     <= S_RD_LO;  // no reads while a beat waits
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && i_req_valid)
			o_tdata <= i_req.word;
		if (state == S_RD_HI)
			lo_q <= i_rd_data;
		if (state == S_PACK)
			o_tdata <= {{PAD{1'b0}}, i_rd_data, {PAD{1'b0}}, lo_q};
	end

endmodule

// File: hdl/scope_top.sv
// digitizer command and acquisition core
// byte command stream in, 32-bit reply stream out, one adc sample
// per clock into the circular buffer

module scope_top
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;
(
	input  logic        clk,
	input  logic        rstn,
	input  logic        i_tvalid,
	input  logic [7:0]  i_tdata,
	output logic        o_tready,
	output logic        o_tvalid,
	output logic [31:0] o_tdata,
	output logic [3:0]  o_tkeep,
	output logic        o_tlast,
	input  logic        i_tready,
	input  sample_t     i_sample
);

	cmd_t        cmd;
	logic        cmd_valid;
	logic        cmd_done;
	trig_cfg_t   trig_cfg;
	logic        trig_arm;
	logic        trig_release;
	acq_status_t acq_status;
	resp_req_t   resp_req;
	logic        resp_valid;
	logic        resp_done;
	logic        wr_en;
	ram_addr_t   wr_addr;
	sample_t     wr_data;
	ram_addr_t   rd_addr;
	sample_t     rd_data;

	// ------------------------------------------------------------------
	// command path
	// ------------------------------------------------------------------
	cmd_receiver u_rx (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .i_tdata(i_tdata), .o_tready(o_tready),
		.i_cmd_done(cmd_done), .o_cmd(cmd), .o_cmd_valid(cmd_valid)
	);

	cmd_executor u_exec (
		.clk(clk), .rstn(rstn),
		.i_cmd(cmd), .i_cmd_valid(cmd_valid), .o_cmd_done(cmd_done),
		.o_trig_cfg(trig_cfg), .o_arm(trig_arm), .o_release(trig_release),
		.i_acq_status(acq_status),
		.o_resp_req(resp_req), .o_resp_valid(resp_valid), .i_resp_done(resp_done)
	);

	// ------------------------------------------------------------------
	// acquisition and readout
	// ------------------------------------------------------------------
	trigger_engine u_trig (
		.clk(clk), .rstn(rstn),
		.i_sample(i_sample), .i_cfg(trig_cfg),
		.i_arm(trig_arm), .i_release(trig_release), .o_status(acq_status),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

	sample_buffer u_buf (
		.clk(clk),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	response_streamer u_tx (
		.clk(clk), .rstn(rstn),
		.i_req(resp_req), .i_req_valid(resp_valid), .o_req_done(resp_done),
		.o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tvalid(o_tvalid), .o_tdata(o_tdata), .o_tkeep(o_tkeep),
		.o_tlast(o_tlast), .i_tready(i_tready)
	);

endmodule

// File: dv/tb_clkgen.sv
// testbench clock generator
// free running clock, starts low

module tb_clkgen #(
	parameter int PERIOD = 40
) (
	output logic o_clk
);

	initial o_clk = 1'b0;

	always #(PERIOD / 2) o_clk = ~o_clk;  // half period high, half low

endmodule

// File: dv/tb_scope.sv
// digitizer core testbench
// sends host commands, drives trigger waveforms, checks reply beats
// against a reference model under random output back-pressure

module tb_scope
	import scope_cmd_pkg::*;
	import scope_acq_pkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam int N_TESTS    = 6;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  keep;
		logic        last;
	} beat_t;

	logic        clk;
	logic        rstn;
	logic        i_tvalid;
	logic [7:0]  i_tdata;
	logic        o_tready;
	logic        o_tvalid;
	logic [31:0] o_tdata;
	logic [3:0]  o_tkeep;
	logic        o_tlast;
	logic        i_tready;
	sample_t     i_sample;

	beat_t  exp_q [$];
	beat_t  act_q [$];
	integer seed = 32'h832a5f67;
	int     err_cnt, beat_cnt, test_no, failed_tests, err_at_start;
	int     m_lower, m_upper, m_pre, m_tot, m_type;   // trigger model
	int     ev_cnt;
	bit     held;                                     // event waiting for readout
	int     wave [0:127];                             // samples driven since arming
	int     wave_len;

	tb_clkgen #(.PERIOD(CLK_PERIOD)) u_clk (.o_clk(clk));

	scope_top DUT (
		.clk(clk), .rstn(rstn),
		.i_tvalid(i_tvalid), .i_tdata(i_tdata), .o_tready(o_tready),
		.o_tvalid(o_tvalid), .o_tdata(o_tdata), .o_tkeep(o_tkeep),
		.o_tlast(o_tlast), .i_tready(i_tready), .i_sample(i_sample)
	);

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------
	function automatic cmd_t make_cmd(input logic [7:0] op, a1, a2, a3, a4, a5, a6, a7);
		return {a7, a6, a5, a4, a3, a2, a1, op};
	endfunction

	function automatic logic [31:0] lane_mask(input logic [3:0] keep);
		logic [31:0] m;
		for (int i = 0; i < 4; i++)
			m[8*i +: 8] = {8{keep[i]}};
		return m;
	endfunction

	// index of the firing sample in the recorded waveform
	function automatic int find_fire();
		bit first_seen;
		int cnt;
		first_seen = 0;
		cnt        = 0;
		for (int i = 0; i < wave_len; i++) begin
			if (!first_seen) begin
				if (m_type == 1 ? wave[i] < m_lower : wave[i] > m_upper)
					first_seen = 1;
			end else if (m_type == 1 ? wave[i] > m_upper : wave[i] < m_lower) begin
				if (cnt == m_tot)
					return i;
				cnt++;
			end
		end
		return -1;
	endfunction

	function automatic int ref_count(input cmd_t c);
		case (c[0])
			8'd0:       return (int'(c[7:4]) + 3) / 4;
			8'd1, 8'd8: return 1;
			8'd2:       return (c[1] == 8'd0) ? 1 : 0;
			default:    return 0;
		endcase
	endfunction

	function automatic beat_t ref_beat(input cmd_t c, input int k);
		beat_t b;
		int    rem;
		int    start;
		b.data = '0;
		b.keep = 4'hf;
		b.last = 1'b1;
		case (c[0])
			8'd0: begin
				rem    = int'(c[7:4]) - 4 * k;
				start  = find_fire() - m_pre;
				b.keep = (rem >= 4) ? 4'hf : 4'((1 << rem) - 1);
				b.last = (rem <= 4);
				b.data = {4'h0, 12'(wave[start + 2*k + 1]), 4'h0, 12'(wave[start + 2*k])};
				b.data = b.data & lane_mask(b.keep);
			end
			8'd1:    b.data = {16'(ev_cnt), held ? 16'hffff : 16'h0000};
			8'd2:    b.data = 32'h10;
			8'd8:    b.data = 32'h25;
			default: ;
		endcase
		return b;
	endfunction

	// ------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------
	task automatic send_cmd(input cmd_t c);
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			while (!o_tready) @(negedge clk);
			i_tvalid = 1'b1;
			i_tdata  = c[i];
		end
		@(negedge clk);
		i_tvalid = 1'b0;
	endtask

	task automatic run_cmd(input cmd_t c);
		int n;
		n = ref_count(c);
		for (int k = 0; k < n; k++)
			exp_q.push_back(ref_beat(c, k));
		send_cmd(c);
		if (o_tready) begin
			$display("[FAIL] o_tready expected 0x0, actual 0x%h", o_tready);
			err_cnt++;
		end
		while (!o_tready) @(negedge clk);  // receiver reopens after the reply
		@(negedge clk);
		if (exp_q.size() != 0) begin
			$display("reply to opcode 0x%h ended with %0d beats missing", c[0], exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
		if (c[0] == 8'd0)
			held = 0;  // dump releases the engine
	endtask

	task automatic set_trigger(input int center, input int half, input int pre, input int tot);
		run_cmd(make_cmd(8'h08, 8'(center), 8'(half), 8'(pre >> 8), 8'(pre), 8'(tot),
		                 8'h00, 8'h00));
		m_lower = (center - half - 128) * 16 + 8;
		m_upper = (center + half - 128) * 16 + 8;
		m_pre   = pre;
		m_tot   = tot;
	endtask

	task automatic arm_trigger(input int ttype, input int post);
		run_cmd(make_cmd(8'h01, 8'(ttype), 8'h00, 8'h00, 8'(post), 8'(post >> 8),
		                 8'h00, 8'h00));
		m_type = ttype;
	endtask

	task automatic put_sample(input int v);
		@(negedge clk);
		i_sample       = sample_t'(v);
		wave[wave_len] = v;
		wave_len++;
	endtask

	// quiet level past one threshold, then a ramp across the other
	task automatic drive_event(input bit rising);
		wave_len = 0;
		for (int k = 0; k < m_pre + 8; k++)
			put_sample(rising ? m_upper + 5 : m_lower - 5);
		for (int k = 0; k < 60; k++)
			put_sample(rising ? m_lower - 1 - k : m_upper + 1 + k);
		@(negedge clk);
		i_sample = '0;
		if (find_fire() >= 0) begin
			ev_cnt++;
			held = 1;
		end
	endtask

	task automatic begin_test();
		err_at_start = err_cnt;
		test_no++;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == err_at_start) begin
			$display("test %0d %s: pass", test_no, name);
		end else begin
			$display("test %0d %s: %0d errors", test_no, name, err_cnt - err_at_start);
			failed_tests++;
		end
	endtask

	// ------------------------------------------------------------------
	// back-pressure, collection and comparison
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		i_tready = (($random(seed) & 3) != 0);  // ready about 3 cycles in 4
		if (rstn && o_tvalid && i_tready)
			act_q.push_back({o_tdata, o_tkeep, o_tlast});
	end

	always @(posedge clk) begin
		beat_t       a;
		beat_t       e;
		logic [31:0] m;
		while (act_q.size() > 0) begin
			a = act_q.pop_front();
			beat_cnt++;
			if (exp_q.size() == 0) begin
				$display("reply beat 0x%h arrived when none was expected", a.data);
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				m = lane_mask(e.keep);
				if ((a.data & m) != e.data) begin
					$display("[FAIL] o_tdata expected 0x%h, actual 0x%h", e.data, a.data & m);
					err_cnt++;
				end
				if (a.keep != e.keep) begin
					$display("[FAIL] o_tkeep expected 0x%h, actual 0x%h", e.keep, a.keep);
					err_cnt++;
				end
				if (a.last != e.last) begin
					$display("[FAIL] o_tlast expected 0x%h, actual 0x%h", e.last, a.last);
					err_cnt++;
				end
			end
		end
	end

	initial begin
		#(N_TESTS * 2000 * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Checks failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		rstn     = 1'b0;
		i_tvalid = 1'b0;
		i_tdata  = '0;
		i_tready = 1'b0;
		i_sample = '0;
		wave_len = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
		repeat (2) @(negedge clk);

		begin_test();
		run_cmd(make_cmd(8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));
		end_test("version read");

		begin_test();
		set_trigger(128, 10, 4, 0);
		arm_trigger(1, 40);
		end_test("settings and arm");

		begin_test();
		drive_event(0);
		arm_trigger(1, 40);  // held, so only reads the status
		end_test("falling trigger");

		begin_test();
		run_cmd(make_cmd(8'h00, 8'h00, 8'h00, 8'h00, 8'd22, 8'h00, 8'h00, 8'h00));
		end_test("dump with back-pressure");

		begin_test();
		set_trigger(128, 10, 0, 2);
		arm_trigger(2, 40);
		drive_event(1);
		arm_trigger(2, 40);
		run_cmd(make_cmd(8'h00, 8'h00, 8'h00, 8'h00, 8'd16, 8'h00, 8'h00, 8'h00));
		end_test("rising trigger with tot");

		begin_test();
		run_cmd(make_cmd(8'h55, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));
		run_cmd(make_cmd(8'h02, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00));
		end_test("unknown opcode");

		$display("tests %0d, failed %0d, beats checked %0d, errors %0d",
		         test_no, failed_tests, beat_cnt, err_cnt);
		if (err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: files.f
+incdir+hdl
hdl/scope_cmd_pkg.sv
hdl/scope_acq_pkg.sv
hdl/cmd_receiver.sv
hdl/cmd_executor.sv
hdl/trigger_engine.sv
hdl/sample_buffer.sv
hdl/response_streamer.sv
hdl/scope_top.sv
dv/tb_clkgen.sv
dv/tb_scope.sv
